/* verilog/anim_pkg.sv */
package anim_pkg;

    // widths of the player datapath
    localparam int ANIM_W  = 6;                 // animation number 0..63
    localparam int FRAME_W = 6;                 // frame index and limit, 63 must fit
    localparam int SEG_W   = 8;                 // a..g in bits 0..6 plus dp in bit 7

    // animation range
    localparam logic [ANIM_W-1:0] LAST_ANIM = ANIM_W'(40);  // highest defined animation

    // random source
    localparam int               LFSR_W    = 16;            // lfsr state width
    localparam logic [LFSR_W-1:0] LFSR_SEED = 16'hACE1;     // nonzero reset state

    // animations that have their own pattern rule
    localparam logic [ANIM_W-1:0] ANI_DIGIT = ANIM_W'(0);   // decimal counter 0..9
    localparam logic [ANIM_W-1:0] ANI_PAIR  = ANIM_W'(6);   // a+d / b+e switcher
    localparam logic [ANIM_W-1:0] ANI_BLINK = ANIM_W'(10);  // all on then all off

endpackage

/* verilog/frame_limit.sv */
`timescale 1ns/1ns

module frame_limit (
    input  logic [anim_pkg::ANIM_W-1:0]  animation,     // current animation number
    output logic [anim_pkg::FRAME_W-1:0] limit          // last frame index of it
);

    localparam int FW = anim_pkg::FRAME_W;

    int unsigned last_idx;                              // table value before sizing

    always_comb begin
        case (animation)
            0:                  last_idx = 9;           // digits 0 to 9
            1:                  last_idx = 11;          // twelve frame intro
            2, 3, 4, 5:         last_idx = 5;           // spinners one lap
            6:                  last_idx = 5;           // pair switcher
            7:                  last_idx = 1;           // up and down
            8:                  last_idx = 3;           // up and down straight
            9:                  last_idx = 3;           // bar shapes
            10:                 last_idx = 1;           // blink
            11:                 last_idx = 1;           // low o and high o
            12:                 last_idx = 1;           // right and left
            13, 14:             last_idx = 1;           // half h variants
            15:                 last_idx = 3;           // circle down
            16:                 last_idx = 4;           // five letter word
            17:                 last_idx = 1;           // slanted pair
            18, 19, 20, 21, 22: last_idx = 6;           // short random runs
            23:                 last_idx = 3;           // circle up
            24, 25, 26, 27:     last_idx = 15;          // longer random runs
            28:                 last_idx = 31;          // random numbers plus
            29:                 last_idx = 3;           // pulse
            30:                 last_idx = 10;          // eleven frame greeting
            31:                 last_idx = 31;          // longest random run
            32:                 last_idx = 4;           // second pulse
            33:                 last_idx = 8;           // nine frame sequence
            34, 35, 36, 37:     last_idx = 4;           // five frame slots
            38, 39, 40:         last_idx = 4;           // last defined slots
            default:            last_idx = 63;          // undefined runs full range
        endcase
    end

    assign limit = FW'(last_idx);                       // size to frame width

endmodule

/* verilog/frame_timer.sv */
`timescale 1ns/1ns

module frame_timer #(
    parameter int TICK_DIV = 8                          // clocks per frame
) (
    input  logic clk,
    input  logic rst_n,
    input  logic restart,                               // reload for a fresh full frame
    output logic frame_tick                             // one cycle per frame
);

    localparam int               CNT_W  = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;
    localparam logic [CNT_W-1:0] RELOAD = CNT_W'(TICK_DIV - 1);

    logic [CNT_W-1:0] cnt;                              // clocks left in this frame

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt        <= RELOAD;                       // full frame after reset
            frame_tick <= 1'b0;
        end else if (restart) begin
            cnt        <= RELOAD;                       // new animation gets a whole frame
            frame_tick <= 1'b0;
        end else if (cnt == '0) begin
            cnt        <= RELOAD;                       // period wraps
            frame_tick <= 1'b1;                         // pulse once
        end else begin
            cnt        <= cnt - 1'b1;
            frame_tick <= 1'b0;
        end
    end

endmodule

/* verilog/lfsr16.sv */
`timescale 1ns/1ns

module lfsr16 (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         step,          // advance once per frame
    output logic [anim_pkg::LFSR_W-1:0]  rand_bits      // current lfsr state
);

    logic [anim_pkg::LFSR_W-1:0] state;                 // shift register
    logic                        feedback;              // new bit into bit 0

    // taps 16 14 13 11 give a maximal length sequence
    assign feedback = state[15] ^ state[13] ^ state[12] ^ state[10];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= anim_pkg::LFSR_SEED;               // known start for repeatable frames
        end else if (step) begin
            state <= {state[14:0], feedback};           // shift up, fill bit 0
        end
    end

    assign rand_bits = state;

endmodule

/* verilog/segment_patterns.sv */
`timescale 1ns/1ns

module segment_patterns (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic [anim_pkg::ANIM_W-1:0]  animation,     // selects the pattern rule
    input  logic [anim_pkg::FRAME_W-1:0] frame,         // position inside the animation
    input  logic [anim_pkg::LFSR_W-1:0]  rand_bits,     // random source for noise frames
    output logic [anim_pkg::SEG_W-1:0]   segments       // dp g f e d c b a, active high
);

    localparam int FW = anim_pkg::FRAME_W;
    localparam int SW = anim_pkg::SEG_W;

    localparam logic [6:0] SEG_ALL = 7'b111_1111;       // every bar lit
    localparam logic [6:0] SEG_AD  = 7'b000_1001;       // top and bottom
    localparam logic [6:0] SEG_BE  = 7'b001_0010;       // upper right and lower left
    localparam logic [6:0] SEG_A   = 7'b000_0001;       // start of clockwise lap
    localparam logic [6:0] SEG_F   = 7'b010_0000;       // start of anticlockwise lap

    logic [FW-1:0]  frame_mod6;                         // position within one lap
    logic [2:0]     lap_pos;                            // 0..5
    logic [SW-1:0]  seg_nxt;                            // pattern before the register

    // standard hex font, bit 0 is segment a
    function automatic logic [6:0] hex_font(input logic [3:0] digit);
        logic [6:0] font;
        case (digit)
            4'h0:    font = 7'h3F;
            4'h1:    font = 7'h06;
            4'h2:    font = 7'h5B;
            4'h3:    font = 7'h4F;
            4'h4:    font = 7'h66;
            4'h5:    font = 7'h6D;
            4'h6:    font = 7'h7D;
            4'h7:    font = 7'h07;
            4'h8:    font = 7'h7F;
            4'h9:    font = 7'h6F;
            4'hA:    font = 7'h77;
            4'hB:    font = 7'h7C;                      // lower case b
            4'hC:    font = 7'h39;
            4'hD:    font = 7'h5E;                      // lower case d
            4'hE:    font = 7'h79;
            default: font = 7'h71;                      // F
        endcase
        return font;
    endfunction

    assign frame_mod6 = frame % FW'(6);                 // six outer bars per lap
    assign lap_pos    = frame_mod6[2:0];                // value fits in three bits

    always_comb begin
        case (animation)
            anim_pkg::ANI_DIGIT: begin
                seg_nxt = {1'b0, hex_font(frame[3:0])}; // frame stays within 0..9
            end
            2, 4, 15: begin
                seg_nxt = {1'b0, SEG_A << lap_pos};     // a b c d e f
            end
            3, 5, 23: begin
                seg_nxt = {1'b0, SEG_F >> lap_pos};     // f e d c b a
            end
            anim_pkg::ANI_PAIR: begin
                seg_nxt = {1'b0, frame[0] ? SEG_BE : SEG_AD};   // swap pair every frame
            end
            anim_pkg::ANI_BLINK: begin
                seg_nxt = {1'b0, (frame == '0) ? SEG_ALL : 7'b000_0000};
            end
            18, 19, 20, 21, 22, 24, 25, 26, 27, 28, 31: begin
                seg_nxt = {frame[0], rand_bits[6:0]};   // noise with dp toggling
            end
            default: begin
                seg_nxt = {1'b1, hex_font(frame[3:0])}; // hex of frame with dp on
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            segments <= '0;                             // blank display in reset
        end else begin
            segments <= seg_nxt;                        // one cycle behind the inputs
        end
    end

endmodule

/* verilog/anim_sequencer.sv */
`timescale 1ns/1ns

module anim_sequencer (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         frame_tick,    // advance one frame
    input  logic                         load_anim,     // strobe with anim_sel valid
    input  logic [anim_pkg::ANIM_W-1:0]  anim_sel,      // animation to load
    input  logic                         auto_advance,  // move on after each wrap
    input  logic [anim_pkg::FRAME_W-1:0] limit,         // last frame of current animation
    output logic [anim_pkg::ANIM_W-1:0]  animation,
    output logic [anim_pkg::FRAME_W-1:0] frame
);

    logic                         at_limit;             // this frame is the last one
    logic                         past_last;            // wrap animation back to 0
    logic [anim_pkg::ANIM_W-1:0]  anim_following;       // animation after this one
    logic [anim_pkg::ANIM_W-1:0]  anim_nxt;
    logic [anim_pkg::FRAME_W-1:0] frame_nxt;

    assign at_limit       = (frame == limit);
    assign past_last      = (animation >= anim_pkg::LAST_ANIM);    // also catches loaded 41..63
    assign anim_following = past_last ? '0 : animation + 1'b1;

    always_comb begin
        anim_nxt  = animation;                          // hold by default
        frame_nxt = frame;
        if (load_anim) begin
            anim_nxt  = anim_sel;                       // load wins over a tick
            frame_nxt = '0;
        end else if (frame_tick) begin
            if (at_limit) begin
                frame_nxt = '0;                         // wrap to first frame
                if (auto_advance) begin
                    anim_nxt = anim_following;          // playlist mode
                end
            end else begin
                frame_nxt = frame + 1'b1;               // next frame
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            animation <= '0;
            frame     <= '0;
        end else begin
            animation <= anim_nxt;
            frame     <= frame_nxt;
        end
    end

endmodule

/* verilog/seg_player_top.sv */
`timescale 1ns/1ns

module seg_player_top #(
    parameter int TICK_DIV = 8                          // clocks per frame
) (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic [anim_pkg::ANIM_W-1:0]  anim_sel,      // animation to load
    input  logic                         load_anim,     // one cycle load strobe
    input  logic                         auto_advance,  // play all animations in turn
    output logic [anim_pkg::SEG_W-1:0]   segments,      // to the display driver
    output logic [anim_pkg::ANIM_W-1:0]  animation,     // current animation
    output logic [anim_pkg::FRAME_W-1:0] frame          // current frame index
);

    logic                         frame_tick;           // frame rate strobe
    logic [anim_pkg::FRAME_W-1:0] limit;                // last frame of animation
    logic [anim_pkg::LFSR_W-1:0]  rand_bits;            // noise for random animations

    frame_timer #(
        .TICK_DIV   (TICK_DIV)
    ) timer_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .restart    (load_anim),                        // new animation starts a full frame
        .frame_tick (frame_tick)
    );

    lfsr16 lfsr_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .step       (frame_tick),                       // noise changes at frame rate
        .rand_bits  (rand_bits)
    );

    anim_sequencer seq_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .frame_tick   (frame_tick),
        .load_anim    (load_anim),
        .anim_sel     (anim_sel),
        .auto_advance (auto_advance),
        .limit        (limit),
        .animation    (animation),
        .frame        (frame)
    );

    frame_limit limit_i (
        .animation  (animation),
        .limit      (limit)                             // back to the sequencer
    );

    segment_patterns pat_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .animation  (animation),
        .frame      (frame),
        .rand_bits  (rand_bits),
        .segments   (segments)                          // registered pattern
    );

endmodule

/* sim/tb_seg_player.sv */
`timescale 1ns/1ns

module tb_seg_player;

    localparam int AW         = anim_pkg::ANIM_W;
    localparam int FW         = anim_pkg::FRAME_W;
    localparam int SW         = anim_pkg::SEG_W;
    localparam int LW         = anim_pkg::LFSR_W;
    localparam int WAIT_LIMIT = 200;                    // cycles allowed per frame change

    // gfedcba font for 0..F
    localparam logic [6:0] FONT [16] = '{
        7'b0111111, 7'b0000110, 7'b1011011, 7'b1001111,
        7'b1100110, 7'b1101101, 7'b1111101, 7'b0000111,
        7'b1111111, 7'b1101111, 7'b1110111, 7'b1111100,
        7'b0111001, 7'b1011110, 7'b1111001, 7'b1110001
    };
    localparam logic [AW-1:0] DIRECTED [10] = '{0, 1, 2, 3, 6, 10, 15, 19, 23, 31};

    logic          clk;
    logic          rst_n;
    logic [AW-1:0] anim_sel;
    logic          load_anim;
    logic          auto_advance;
    logic [SW-1:0] segments;
    logic [AW-1:0] animation;
    logic [FW-1:0] frame;

    logic [AW-1:0] exp_anim;                            // model state after the last edge
    logic [FW-1:0] exp_frame;
    logic [LW-1:0] exp_lfsr;
    logic [AW-1:0] prev_anim;                           // state that fed the segment register
    logic [FW-1:0] prev_frame;
    logic [LW-1:0] prev_lfsr;
    logic          seg_armed;                           // segments left their reset value
    logic          load_seen;                           // inputs the dut saw at the last edge
    logic [AW-1:0] sel_seen;
    logic          auto_seen;

    int     mon_errors;
    int     seq_errors;
    int     timeouts;
    logic   aborted;                                    // a wait timed out, skip the rest
    string  test_name;
    integer seed;

    seg_player_top #(
        .TICK_DIV     (8)
    ) dut_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .anim_sel     (anim_sel),
        .load_anim    (load_anim),
        .auto_advance (auto_advance),
        .segments     (segments),
        .animation    (animation),
        .frame        (frame)
    );

    always #5 clk = ~clk;                               // 10 ns period

    // last frame index per animation
    function automatic logic [FW-1:0] limit_of(input logic [AW-1:0] a);
        int unsigned n;
        int unsigned lim;
        n = a;
        if (n == 0)        lim = 9;
        else if (n == 1)   lim = 11;
        else if (n <= 6)   lim = 5;
        else if (n == 7)   lim = 1;
        else if (n <= 9)   lim = 3;
        else if (n <= 14)  lim = 1;
        else if (n == 15)  lim = 3;
        else if (n == 16)  lim = 4;
        else if (n == 17)  lim = 1;
        else if (n <= 22)  lim = 6;
        else if (n == 23)  lim = 3;
        else if (n <= 27)  lim = 15;
        else if (n == 28)  lim = 31;
        else if (n == 29)  lim = 3;
        else if (n == 30)  lim = 10;
        else if (n == 31)  lim = 31;
        else if (n == 32)  lim = 4;
        else if (n == 33)  lim = 8;
        else if (n <= 40)  lim = 4;
        else               lim = 63;                    // undefined numbers
        return FW'(lim);
    endfunction

    function automatic logic [AW-1:0] next_anim(input logic [AW-1:0] a);
        logic [AW-1:0] nxt;
        nxt = (a >= anim_pkg::LAST_ANIM) ? '0 : a + 1'b1;   // 40 and above go back to 0
        return nxt;
    endfunction

    function automatic logic [LW-1:0] lfsr_step(input logic [LW-1:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};    // taps 16 14 13 11
    endfunction

    function automatic logic is_random(input logic [AW-1:0] a);
        return (a >= 18 && a <= 22) || (a >= 24 && a <= 28) || (a == 31);
    endfunction

    function automatic logic [SW-1:0] seg_of(input logic [AW-1:0] a, input logic [FW-1:0] f,
                                              input logic [LW-1:0] r);
        logic [2:0]    pos;
        logic [SW-1:0] seg;
        pos = 3'(f % 6);                                // place on the outer ring
        if (a == anim_pkg::ANI_DIGIT)
            seg = {1'b0, FONT[4'(f % 10)]};
        else if (a == 2 || a == 4 || a == 15)
            seg = {1'b0, 7'(1 << pos)};                 // a first, f last
        else if (a == 3 || a == 5 || a == 23)
            seg = {1'b0, 7'(1 << (5 - pos))};           // f first, a last
        else if (a == anim_pkg::ANI_PAIR)
            seg = f[0] ? 8'h12 : 8'h09;                 // b+e on odd, a+d on even
        else if (a == anim_pkg::ANI_BLINK)
            seg = (f == '0) ? 8'h7F : 8'h00;
        else if (is_random(a))
            seg = {f[0], r[6:0]};
        else
            seg = {1'b1, FONT[f[3:0]]};                 // hex with dp
        return seg;
    endfunction

    // compare process, runs where all dut outputs are settled
    always @(negedge clk) begin
        if (!rst_n) begin
            exp_anim  = '0;
            exp_frame = '0;
            exp_lfsr  = anim_pkg::LFSR_SEED;
            seg_armed = 1'b0;
            load_seen = 1'b0;
            sel_seen  = '0;
            auto_seen = 1'b0;
        end else begin
            prev_anim  = exp_anim;
            prev_frame = exp_frame;
            prev_lfsr  = exp_lfsr;
            if (load_seen) begin
                exp_anim  = sel_seen;
                exp_frame = '0;
            end else if (frame != exp_frame) begin      // frame moved so a tick happened
                exp_lfsr = lfsr_step(exp_lfsr);
                if (exp_frame == limit_of(exp_anim)) begin
                    exp_frame = '0;
                    if (auto_seen)
                        exp_anim = next_anim(exp_anim);
                end else begin
                    exp_frame = exp_frame + 1'b1;
                end
            end
            if (animation !== exp_anim) begin
                $display("ERROR %s animation: expected %0d, actual %0d",
                         test_name, exp_anim, animation);
                mon_errors++;
            end
            if (frame !== exp_frame) begin
                $display("ERROR %s frame: expected %0d, actual %0d", test_name, exp_frame, frame);
                mon_errors++;
            end
            if (!seg_armed && segments !== '0) begin
                $display("ERROR %s segments: expected 00, actual %h", test_name, segments);
                mon_errors++;
            end
            if (seg_armed && segments !== seg_of(prev_anim, prev_frame, prev_lfsr)) begin
                $display("ERROR %s segments: expected %h, actual %h (anim %0d frame %0d)",
                         test_name, seg_of(prev_anim, prev_frame, prev_lfsr), segments,
                         prev_anim, prev_frame);
                mon_errors++;
            end
            seg_armed = 1'b1;
            load_seen = load_anim;                      // used by the dut at the next edge
            sel_seen  = anim_sel;
            auto_seen = auto_advance;
        end
    end

    task automatic wait_frame_change();
        logic [FW-1:0] start;
        int            cycles;
        start  = frame;
        cycles = 0;
        if (aborted)
            return;
        while (frame == start && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (frame == start) begin
            $display("timeout in %s: frame stuck at %0d for %0d cycles",
                     test_name, start, WAIT_LIMIT);
            timeouts++;
            aborted = 1'b1;
        end
    endtask

    // right after a frame change, so no tick lands on the load
    task automatic load_animation(input logic [AW-1:0] sel, input logic adv);
        @(posedge clk);
        anim_sel     <= sel;
        load_anim    <= 1'b1;
        auto_advance <= adv;
        @(posedge clk);
        load_anim    <= 1'b0;
        @(negedge clk);
        if (animation !== sel) begin
            $display("ERROR %s load animation: expected %0d, actual %0d", test_name, sel, animation);
            seq_errors++;
        end
        if (frame !== '0) begin
            $display("ERROR %s load frame: expected 0, actual %0d", test_name, frame);
            seq_errors++;
        end
    endtask

    // walk frames 1..limit, then the wrap
    task automatic play_through(input logic [AW-1:0] anim, input logic adv);
        logic [FW-1:0] last;
        logic [AW-1:0] after;
        last  = limit_of(anim);
        after = adv ? next_anim(anim) : anim;
        for (int i = 1; i <= int'(last); i++) begin
            wait_frame_change();
            if (aborted)
                return;
            if (frame !== FW'(i) || animation !== anim) begin
                $display("ERROR %s step: expected %0d/%0d, actual %0d/%0d",
                         test_name, anim, i, animation, frame);
                seq_errors++;
            end
        end
        wait_frame_change();
        if (aborted)
            return;
        if (frame !== '0 || animation !== after) begin
            $display("ERROR %s wrap: expected %0d/0, actual %0d/%0d",
                     test_name, after, animation, frame);
            seq_errors++;
        end
    endtask

    task automatic finish_run();
        $display("errors: compare %0d, sequence %0d, timeouts %0d",
                 mon_errors, seq_errors, timeouts);
        if (mon_errors + seq_errors + timeouts == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    endtask

    initial begin
        logic [AW-1:0] sel;
        integer        r;
        clk          = 1'b0;
        rst_n        = 1'b0;
        anim_sel     = '0;
        load_anim    = 1'b0;
        auto_advance = 1'b0;
        mon_errors   = 0;
        seq_errors   = 0;
        timeouts     = 0;
        aborted      = 1'b0;
        test_name    = "reset";
        seed         = 32'h93c5_cdee;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        if (animation !== '0 || frame !== '0 || segments !== '0) begin
            $display("ERROR reset state: expected 0/0/00, actual %0d/%0d/%h",
                     animation, frame, segments);
            seq_errors++;
        end
        wait_frame_change();
        if (frame !== FW'(1)) begin
            $display("ERROR reset first frame: expected 1, actual %0d", frame);
            seq_errors++;
        end

        test_name = "directed load";
        foreach (DIRECTED[i]) begin
            load_animation(DIRECTED[i], 1'b0);
            play_through(DIRECTED[i], 1'b0);
        end

        test_name = "random load";
        repeat (6) begin
            r   = $random(seed);
            sel = AW'($unsigned(r) % 41);
            load_animation(sel, 1'b0);
            play_through(sel, 1'b0);
        end

        test_name = "auto advance";
        sel = AW'(38);
        load_animation(sel, 1'b1);
        repeat (4) begin                                // 38 39 40 then 0
            play_through(sel, 1'b1);
            sel = next_anim(sel);
        end

        test_name = "undefined 45";
        load_animation(AW'(45), 1'b1);
        play_through(AW'(45), 1'b1);

        finish_run();
    end

endmodule

/* filelist.f */
verilog/anim_pkg.sv
verilog/frame_limit.sv
verilog/frame_timer.sv
verilog/lfsr16.sv
verilog/segment_patterns.sv
verilog/anim_sequencer.sv
verilog/seg_player_top.sv
sim/tb_seg_player.sv

/* run_sim.sh */
#!/bin/sh
# build the seven segment player testbench with verilator, run it, scan the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ns -Wno-fatal --top-module tb_seg_player \
    -f filelist.f --Mdir obj_dir -o tb_seg_player > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/tb_seg_player > sim.log 2>&1 || { cat sim.log; echo "simulation aborted"; exit 1; }

cat sim.log
grep -q "TESTBENCH FAILED" sim.log && { echo "simulation failed"; exit 1; }
echo "simulation passed"
